/* include/avr_settings.svh */
`ifndef AVR_SETTINGS_SVH
`define AVR_SETTINGS_SVH

// Byte lanes of the datapath
`define AVR_DATA_W 8

// Program counter and data address width
`define AVR_ADDR_W 16

// General purpose registers r0 to r31
`define AVR_NUM_REGS 32

// Y pointer lives in r29:r28
`define AVR_BASE_Y 28

// Z pointer lives in r31:r30
`define AVR_BASE_Z 30

// First word fetched out of reset
`define AVR_RESET_PC 16'h0000

`endif

/* hw/avr_pkg.sv */
`include "avr_settings.svh"

package avr_pkg;

	// Register or data byte
	typedef logic [`AVR_DATA_W-1:0] byte_t;

	// One program word, always 16 bits on AVR
	typedef logic [15:0] word_t;

	// Word address for program, byte address for data
	typedef logic [`AVR_ADDR_W-1:0] addr_t;

	typedef logic [$clog2(`AVR_NUM_REGS)-1:0] reg_idx_t;

	// I T H S V N Z C, bit 7 down to bit 0
	typedef logic [7:0] sreg_t;

	// q field of LDD/STD
	typedef logic [5:0] disp_t;

	// PASS_B covers MOV and LDI
	typedef enum {PASS_B, ADD, ADC, SUB, SBC, AND, OR, EOR} alu_op_t;

	// SECOND only for LD and for taken jumps
	typedef enum {FIRST, SECOND} phase_t;

endpackage

/* hw/avr_decoder.sv */
`timescale 1ns/1ps

module avr_decoder
	import avr_pkg::*;
(
	input word_t opcode,
	output reg_idx_t rd_idx,
	output reg_idx_t rr_idx,
	output byte_t imm,
	output logic use_imm,
	output alu_op_t alu_op,
	output logic writes_rd,
	output logic sets_flags,
	output logic keep_z,
	output logic is_load,
	output logic is_store,
	output logic use_z,
	output disp_t disp,
	output logic is_branch,
	output logic [2:0] br_bit,
	output logic br_set,
	output logic is_rjmp,
	output addr_t offset
);
	// Fields sit in the same place for every form that uses them
	assign rr_idx = {opcode[9], opcode[3:0]};
	assign imm = {opcode[11:8], opcode[3:0]};

	// q is scattered over bits 13, 11:10 and 2:0
	assign disp = {opcode[13], opcode[11:10], opcode[2:0]};
	// Bit 3 clear selects Z, set selects Y
	assign use_z = ~opcode[3];

	// sreg bit under test
	assign br_bit = opcode[2:0];
	// BRBS has bit 10 clear
	assign br_set = ~opcode[10];

	// 12-bit RJMP or 7-bit branch displacement, both signed
	assign offset = is_rjmp ? {{($bits(addr_t) - 12){opcode[11]}}, opcode[11:0]}
		: {{($bits(addr_t) - 7){opcode[9]}}, opcode[9:3]};

	always_comb begin
		rd_idx = opcode[8:4];
		use_imm = 1'b0;
		alu_op = PASS_B;
		writes_rd = 1'b0;
		sets_flags = 1'b0;
		keep_z = 1'b0;
		is_load = 1'b0;
		is_store = 1'b0;
		is_branch = 1'b0;
		is_rjmp = 1'b0;

		casez (opcode)
		// Two register ALU group
		16'b0000_01??_????_????: begin
			// CPC, no result kept
			alu_op = SBC;
			sets_flags = 1'b1;
			keep_z = 1'b1;
		end
		16'b0001_01??_????_????: begin
			// CP
			alu_op = SUB;
			sets_flags = 1'b1;
		end
		16'b0000_10??_????_????: begin
			alu_op = SBC;
			keep_z = 1'b1;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0001_10??_????_????: begin
			alu_op = SUB;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0000_11??_????_????: begin
			// ADD, LSL when rd equals rr
			alu_op = ADD;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0001_11??_????_????: begin
			// ADC, ROL when rd equals rr
			alu_op = ADC;
			keep_z = 1'b1;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0010_00??_????_????: begin
			alu_op = AND;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0010_01??_????_????: begin
			alu_op = EOR;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0010_10??_????_????: begin
			alu_op = OR;
			{writes_rd, sets_flags} = 2'b11;
		end
		16'b0010_11??_????_????: begin
			// MOV leaves sreg alone
			writes_rd = 1'b1;
		end

		// Immediate forms only reach r16..r31
		16'b0011_????_????_????,
		16'b0100_????_????_????,
		16'b0101_????_????_????,
		16'b0110_????_????_????,
		16'b0111_????_????_????,
		16'b1110_????_????_????: begin
			rd_idx = {1'b1, opcode[7:4]};
			use_imm = 1'b1;
			// CPI is the only one that drops its result
			writes_rd = (opcode[15:12] != 4'b0011);
			sets_flags = (opcode[15:12] != 4'b1110);
			case (opcode[15:12])
			4'b0011: alu_op = SUB;
			4'b0100: begin
				alu_op = SBC;
				keep_z = 1'b1;
			end
			4'b0101: alu_op = SUB;
			4'b0110: alu_op = OR;
			4'b0111: alu_op = AND;
			default: alu_op = PASS_B;
			endcase
		end

		// LDD/STD off Y or Z, bit 9 picks store
		16'b10?0_????_????_????: begin
			is_store = opcode[9];
			is_load = ~opcode[9];
		end

		16'b1111_0???_????_????: is_branch = 1'b1;
		16'b1100_????_????_????: is_rjmp = 1'b1;

		// NOP and anything unknown
		default: begin
		end
		endcase
	end

endmodule

/* hw/avr_alu.sv */
`timescale 1ns/1ps

module avr_alu
	import avr_pkg::*;
(
	input logic clk,
	input logic reset,
	input phase_t phase,
	input alu_op_t alu_op,
	input byte_t rd_val,
	input byte_t rr_val,
	input byte_t imm,
	input logic use_imm,
	input logic sets_flags,
	input logic keep_z,
	input logic is_branch,
	input logic [2:0] br_bit,
	input logic br_set,
	output byte_t result,
	output logic branch_taken
);
	// sreg bit positions
	localparam int SREG_H = 5;
	localparam int SREG_S = 4;
	localparam int SREG_V = 3;
	localparam int SREG_N = 2;
	localparam int SREG_Z = 1;
	localparam int SREG_C = 0;

	sreg_t sreg;
	sreg_t next_sreg;
	byte_t b;
	logic carry_in;
	logic h, v, c, z;

	assign b = use_imm ? imm : rr_val;
	assign carry_in = sreg[SREG_C];

	always_comb begin
		case (alu_op)
		ADD: result = rd_val + b;
		ADC: result = rd_val + b + byte_t'(carry_in);
		SUB: result = rd_val - b;
		SBC: result = rd_val - b - byte_t'(carry_in);
		AND: result = rd_val & b;
		OR: result = rd_val | b;
		EOR: result = rd_val ^ b;
		default: result = b;
		endcase
	end

	// Flag equations per instruction class
	always_comb begin
		h = sreg[SREG_H];
		v = sreg[SREG_V];
		c = sreg[SREG_C];
		case (alu_op)
		ADD, ADC: begin
			h = rd_val[3] & b[3] | b[3] & !result[3] | !result[3] & rd_val[3];
			v = rd_val[7] & b[7] & !result[7] | !rd_val[7] & !b[7] & result[7];
			c = rd_val[7] & b[7] | b[7] & !result[7] | !result[7] & rd_val[7];
		end
		SUB, SBC: begin
			h = !rd_val[3] & b[3] | b[3] & result[3] | result[3] & !rd_val[3];
			v = rd_val[7] & !b[7] & !result[7] | !rd_val[7] & b[7] & result[7];
			c = !rd_val[7] & b[7] | b[7] & result[7] | result[7] & !rd_val[7];
		end
		AND, OR, EOR: v = 1'b0;
		default: begin
		end
		endcase

		// Borrow chains only clear Z, never set it
		z = (result == '0);
		if (keep_z && alu_op == SBC)
			z = z & sreg[SREG_Z];

		next_sreg = sreg;
		next_sreg[SREG_H] = h;
		next_sreg[SREG_S] = result[7] ^ v;
		next_sreg[SREG_V] = v;
		next_sreg[SREG_N] = result[7];
		next_sreg[SREG_Z] = z;
		next_sreg[SREG_C] = c;
	end

	// SECOND replays the opcode, so flags only move once
	always_ff @(posedge clk) begin
		if (reset)
			sreg <= '0;
		else if (phase == FIRST && sets_flags)
			sreg <= next_sreg;
	end

	// BRBS takes on a set bit, BRBC on a clear one
	assign branch_taken = is_branch && (sreg[br_bit] == br_set);

endmodule

/* hw/avr_regfile.sv */
`timescale 1ns/1ps
`include "avr_settings.svh"

module avr_regfile
	import avr_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_idx_t rd_idx,
	input reg_idx_t rr_idx,
	input logic wb_en,
	input reg_idx_t wb_idx,
	input byte_t wb_data,
	output byte_t rd_val,
	output byte_t rr_val,
	output addr_t ptr_y,
	output addr_t ptr_z
);
	// Flops, so both reads and the pointer taps are free
	byte_t regs [`AVR_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `AVR_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_idx] <= wb_data;
		end
	end

	assign rd_val = regs[rd_idx];
	assign rr_val = regs[rr_idx];

	// High byte in the odd register
	assign ptr_y = {regs[`AVR_BASE_Y + 1], regs[`AVR_BASE_Y]};
	assign ptr_z = {regs[`AVR_BASE_Z + 1], regs[`AVR_BASE_Z]};

endmodule

/* hw/avr_sequencer.sv */
`timescale 1ns/1ps
`include "avr_settings.svh"

module avr_sequencer
	import avr_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t cdata,
	input logic is_load,
	input logic branch_taken,
	input logic is_rjmp,
	input addr_t offset,
	output word_t opcode,
	output phase_t phase,
	output addr_t pc
);
	// Address of the word now on cdata
	addr_t reg_pc;
	word_t held_op;
	logic jump;

	// Second cycle replays the held opcode
	assign opcode = (phase == FIRST) ? cdata : held_op;

	// Taken branch or RJMP, stays high through SECOND
	assign jump = branch_taken | is_rjmp;

	always_comb begin
		if (phase == FIRST && jump)
			pc = reg_pc + addr_t'(1) + offset;
		else if (jump || (phase == FIRST && is_load))
			// Re-fetch so the right word lines up
			pc = reg_pc;
		else
			pc = reg_pc + addr_t'(1);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// One word below the vector, the idle NOP cycle steps onto it
			reg_pc <= addr_t'(`AVR_RESET_PC) - addr_t'(1);
			phase <= SECOND;
			held_op <= '0;
		end else begin
			reg_pc <= pc;
			if (phase == FIRST) begin
				held_op <= cdata;
				if (jump || is_load)
					phase <= SECOND;
			end else begin
				phase <= FIRST;
			end
		end
	end

endmodule

/* hw/avr_lsu.sv */
`timescale 1ns/1ps

module avr_lsu
	import avr_pkg::*;
(
	input phase_t phase,
	input logic is_load,
	input logic is_store,
	input logic use_z,
	input disp_t disp,
	input addr_t ptr_y,
	input addr_t ptr_z,
	input reg_idx_t rd_idx,
	input byte_t rd_val,
	input logic writes_rd,
	input byte_t result,
	input byte_t data_read,
	output addr_t data_addr,
	output logic data_wen,
	output logic data_ren,
	output byte_t data_write,
	output logic wb_en,
	output reg_idx_t wb_idx,
	output byte_t wb_data
);
	logic load_done;

	// Pointer plus unsigned q
	assign data_addr = (use_z ? ptr_z : ptr_y) + addr_t'(disp);

	// Strobes only once, the replay cycle stays quiet
	assign data_wen = (phase == FIRST) && is_store;
	assign data_ren = (phase == FIRST) && is_load;
	assign data_write = rd_val;

	// Read data is back in the replay cycle
	assign load_done = (phase == SECOND) && is_load;

	assign wb_en = load_done || ((phase == FIRST) && writes_rd);
	assign wb_idx = rd_idx;
	assign wb_data = load_done ? data_read : result;

endmodule

/* hw/avr_core.sv */
`timescale 1ns/1ps

module avr_core
	import avr_pkg::*;
(
	input logic clk,
	input logic reset,
	output addr_t pc,
	input word_t cdata,
	output addr_t data_addr,
	output logic data_wen,
	output logic data_ren,
	input byte_t data_read,
	output byte_t data_write
);
	// Fetch
	word_t opcode;
	phase_t phase;

	// Decode
	reg_idx_t rd_idx;
	reg_idx_t rr_idx;
	byte_t imm;
	logic use_imm;
	alu_op_t alu_op;
	logic writes_rd;
	logic sets_flags;
	logic keep_z;
	logic is_load;
	logic is_store;
	logic use_z;
	disp_t disp;
	logic is_branch;
	logic [2:0] br_bit;
	logic br_set;
	logic is_rjmp;
	addr_t offset;

	// Operands and pointers
	byte_t rd_val;
	byte_t rr_val;
	addr_t ptr_y;
	addr_t ptr_z;

	// Execute
	byte_t result;
	logic branch_taken;

	// Register write port
	logic wb_en;
	reg_idx_t wb_idx;
	byte_t wb_data;

	avr_sequencer u_sequencer (.*);
	avr_decoder u_decoder (.*);
	avr_regfile u_regfile (.*);
	avr_alu u_alu (.*);
	avr_lsu u_lsu (.*);

endmodule

/* tb/avr_core_tb.sv */
`timescale 1ns/1ps
`include "avr_settings.svh"

module avr_core_tb
	import avr_pkg::*;
();
	localparam int STORE_TIMEOUT = 64;
	localparam int NUM_KINDS = 14;
	localparam int NUM_RANDOM = 14;

	typedef enum {
		K_ADD, K_SUB, K_AND, K_OR, K_EOR, K_MOV, K_ADD16,
		K_SUB16, K_SUBI, K_ANDI, K_ORI, K_LOAD, K_BRANCH, K_RJMP
	} kind_t;

	logic clk;
	logic reset = 1'b1;
	addr_t pc;
	word_t cdata = '0;
	addr_t data_addr;
	logic data_wen;
	logic data_ren;
	byte_t data_read = '0;
	byte_t data_write;

	word_t rom [256];
	byte_t ram [256];

	// Test table, one entry per row
	string names [$];
	kind_t kinds [$];
	byte_t op_a [$];
	byte_t op_b [$];

	// Program and expected stores of the row under test
	word_t prog [$];
	addr_t exp_addr [$];
	byte_t exp_data [$];

	int seed = 55238;

	avr_core dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Program ROM, word back one cycle after pc
	always @(posedge clk)
		cdata <= rom[pc[7:0]];

	// Data RAM, low byte of the address only
	always @(posedge clk) begin
		if (data_wen)
			ram[data_addr[7:0]] <= data_write;
		if (data_ren)
			data_read <= ram[data_addr[7:0]];
	end

	// LDI and the register-immediate group
	function automatic word_t imm_op(logic [3:0] opc, reg_idx_t d, byte_t k);
		return {opc, k[7:4], d[3:0], k[3:0]};
	endfunction

	// Two register ALU group, rr bit 4 sits at bit 9
	function automatic word_t reg_op(logic [5:0] opc, reg_idx_t d, reg_idx_t r);
		return {opc, r[4], d, r[3:0]};
	endfunction

	// STD Y+q or Z+q
	function automatic word_t store_op(logic y, disp_t q, reg_idx_t r);
		return {2'b10, q[5], 1'b0, q[4:3], 1'b1, r, y, q[2:0]};
	endfunction

	function automatic word_t load_op(logic y, disp_t q, reg_idx_t d);
		return {2'b10, q[5], 1'b0, q[4:3], 1'b0, d, y, q[2:0]};
	endfunction

	function automatic word_t brbs_op(logic [2:0] s, logic [6:0] k);
		return {6'b111100, k, s};
	endfunction

	function automatic word_t rjmp_op(logic [11:0] k);
		return {4'b1100, k};
	endfunction

	// Expected byte of the final store for the 8-bit rows
	function automatic byte_t alu_model(kind_t k, byte_t a, byte_t b);
		case (k)
		K_ADD: return a + b;
		K_SUB, K_SUBI: return a - b;
		K_AND, K_ANDI: return a & b;
		K_OR, K_ORI: return a | b;
		K_EOR: return a ^ b;
		K_MOV: return b;
		// Skip over the LDI only when CPI saw equal values
		K_BRANCH: return (a == b) ? a : 8'hee;
		default: return a;
		endcase
	endfunction

	task automatic add_row(input string name, input kind_t k, input byte_t a, input byte_t b);
		names.push_back(name);
		kinds.push_back(k);
		op_a.push_back(a);
		op_b.push_back(b);
	endtask

	task automatic expect_store(input addr_t a, input byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic build_program(input kind_t k, input byte_t a, input byte_t b);
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] r;
		logic [5:0] opc6;
		logic [3:0] opc4;
		x = {a, b};
		y = {b, a};
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		case (k)
		K_ADD16, K_SUB16: begin
			prog.push_back(imm_op(4'b1110, 5'd16, x[7:0]));
			prog.push_back(imm_op(4'b1110, 5'd17, x[15:8]));
			prog.push_back(imm_op(4'b1110, 5'd18, y[7:0]));
			prog.push_back(imm_op(4'b1110, 5'd19, y[15:8]));
			// Low byte first, carry or borrow into the high byte
			if (k == K_ADD16) begin
				r = x + y;
				prog.push_back(reg_op(6'b000011, 5'd16, 5'd18));
				prog.push_back(reg_op(6'b000111, 5'd17, 5'd19));
			end else begin
				r = x - y;
				prog.push_back(reg_op(6'b000110, 5'd16, 5'd18));
				prog.push_back(reg_op(6'b000010, 5'd17, 5'd19));
			end
			prog.push_back(store_op(1'b1, 6'd5, 5'd16));
			prog.push_back(store_op(1'b1, 6'd6, 5'd17));
			expect_store(16'd5, r[7:0]);
			expect_store(16'd6, r[15:8]);
		end
		K_SUBI, K_ANDI, K_ORI: begin
			if (k == K_SUBI)
				opc4 = 4'b0101;
			else if (k == K_ANDI)
				opc4 = 4'b0111;
			else
				opc4 = 4'b0110;
			prog.push_back(imm_op(4'b1110, 5'd16, a));
			prog.push_back(imm_op(opc4, 5'd16, b));
			prog.push_back(store_op(1'b1, 6'd5, 5'd16));
			expect_store(16'd5, alu_model(k, a, b));
		end
		K_LOAD: begin
			// Z is zero after reset, so Z+3 is address 3
			prog.push_back(imm_op(4'b1110, 5'd16, a));
			prog.push_back(store_op(1'b0, 6'd3, 5'd16));
			prog.push_back(load_op(1'b0, 6'd3, 5'd18));
			prog.push_back(store_op(1'b1, 6'd9, 5'd18));
			expect_store(16'd3, a);
			expect_store(16'd9, a);
		end
		K_BRANCH: begin
			prog.push_back(imm_op(4'b1110, 5'd16, a));
			prog.push_back(imm_op(4'b0011, 5'd16, b));
			// BRBS on Z over one word
			prog.push_back(brbs_op(3'd1, 7'd1));
			prog.push_back(imm_op(4'b1110, 5'd16, 8'hee));
			prog.push_back(store_op(1'b1, 6'd5, 5'd16));
			expect_store(16'd5, alu_model(k, a, b));
		end
		K_RJMP: begin
			prog.push_back(imm_op(4'b1110, 5'd16, a));
			prog.push_back(rjmp_op(12'd1));
			// Poison value, must never land
			prog.push_back(imm_op(4'b1110, 5'd16, ~a));
			prog.push_back(store_op(1'b1, 6'd5, 5'd16));
			expect_store(16'd5, a);
		end
		default: begin
			case (k)
			K_ADD: opc6 = 6'b000011;
			K_SUB: opc6 = 6'b000110;
			K_AND: opc6 = 6'b001000;
			K_OR: opc6 = 6'b001010;
			K_EOR: opc6 = 6'b001001;
			default: opc6 = 6'b001011;
			endcase
			prog.push_back(imm_op(4'b1110, 5'd16, a));
			prog.push_back(imm_op(4'b1110, 5'd17, b));
			prog.push_back(reg_op(opc6, 5'd16, 5'd17));
			prog.push_back(store_op(1'b1, 6'd5, 5'd16));
			expect_store(16'd5, alu_model(k, a, b));
		end
		endcase
		// Park on a jump to itself
		prog.push_back(rjmp_op(12'hfff));
	endtask

	task automatic check_byte(input string name, input byte_t exp, input byte_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Reset for 5 cycles, ROM loaded while the core is held
	task automatic apply_reset(input string name);
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		for (int i = 0; i < 256; i++)
			rom[i] = '0;
		for (int i = 0; i < prog.size(); i++)
			rom[i] = prog[i];
		repeat (4) begin
			@(negedge clk);
			check_addr({name, " reset pc"}, `AVR_RESET_PC, pc);
			check_flag({name, " reset data_wen"}, 1'b0, data_wen);
			check_flag({name, " reset data_ren"}, 1'b0, data_ren);
		end
		@(posedge clk);
		reset <= 1'b0;
		// Idle cycle right after release
		@(negedge clk);
		check_addr({name, " idle pc"}, `AVR_RESET_PC, pc);
		check_flag({name, " idle data_wen"}, 1'b0, data_wen);
		check_flag({name, " idle data_ren"}, 1'b0, data_ren);
	endtask

	// Next cycle with a write strobe, sampled mid-cycle
	task automatic wait_store(input string name, output addr_t a, output byte_t d);
		int n;
		n = 0;
		@(negedge clk);
		while (data_wen !== 1'b1 && n < STORE_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (data_wen !== 1'b1) begin
			$display("No store arrived within %0d cycles in test %s", STORE_TIMEOUT, name);
			$display("Testbench failed");
			$fatal(1);
		end else begin
			a = data_addr;
			d = data_write;
		end
	endtask

	initial begin
		addr_t got_addr;
		byte_t got_data;
		byte_t a;
		byte_t b;
		add_row("add", K_ADD, 8'h3c, 8'h51);
		add_row("add_carry_out", K_ADD, 8'hf0, 8'h20);
		add_row("sub_borrow", K_SUB, 8'h10, 8'h25);
		add_row("and", K_AND, 8'hca, 8'h6f);
		add_row("or", K_OR, 8'h81, 8'h14);
		add_row("eor", K_EOR, 8'h5a, 8'hff);
		add_row("mov", K_MOV, 8'h11, 8'h9d);
		add_row("add16", K_ADD16, 8'hff, 8'h01);
		add_row("sub16", K_SUB16, 8'h10, 8'h05);
		add_row("subi", K_SUBI, 8'h07, 8'h09);
		add_row("andi", K_ANDI, 8'hb6, 8'h3c);
		add_row("ori", K_ORI, 8'h40, 8'h0a);
		add_row("load", K_LOAD, 8'ha7, 8'h00);
		add_row("branch_equal", K_BRANCH, 8'h42, 8'h42);
		add_row("branch_differ", K_BRANCH, 8'h42, 8'h43);
		add_row("rjmp", K_RJMP, 8'h77, 8'h00);
		// Random operands, every kind in turn
		for (int i = 0; i < NUM_RANDOM; i++) begin
			a = byte_t'($random(seed));
			b = byte_t'($random(seed));
			add_row($sformatf("random_%0d", i), kind_t'(i % NUM_KINDS), a, b);
		end

		for (int i = 0; i < names.size(); i++) begin
			build_program(kinds[i], op_a[i], op_b[i]);
			apply_reset(names[i]);
			for (int s = 0; s < exp_addr.size(); s++) begin
				wait_store(names[i], got_addr, got_data);
				check_addr(names[i], exp_addr[s], got_addr);
				check_byte(names[i], exp_data[s], got_data);
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hw/avr_pkg.sv
hw/avr_decoder.sv
hw/avr_alu.sv
hw/avr_regfile.sv
hw/avr_sequencer.sv
hw/avr_lsu.sv
hw/avr_core.sv
tb/avr_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= avr_core_tb
RTL_TOP ?= avr_core
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
INC_DIR ?= include
VFLAGS ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES ?= hw/avr_pkg.sv hw/avr_decoder.sv hw/avr_alu.sv hw/avr_regfile.sv \
	hw/avr_sequencer.sv hw/avr_lsu.sv hw/avr_core.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) $(RTL_FILES) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
